/* design/hisPkg.sv */
package hisPkg;

    // timestamp width from the TDC front end
    localparam int SAMPLE_W = 10;

    // bin index width, coarse and fine passes share it
    localparam int BIN_W = 4;

    // per-bin counter width, saturates at all ones
    localparam int COUNT_W = 8;

    // bank depth follows from the index width
    localparam int BIN_NUM = 1 << BIN_W;

    // raw photon timestamp
    typedef logic [SAMPLE_W-1:0] sample_t;

    // index into the counter bank
    typedef logic [BIN_W-1:0] bin_t;

    // photons seen in one bin
    typedef logic [COUNT_W-1:0] count_t;

    // which pass the current frame feeds
    typedef enum logic {
        PH_COARSE,
        PH_FINE
    } phase_t;

    // peak finder states
    typedef enum logic [1:0] {
        SC_IDLE,
        SC_READ,
        SC_LAST,
        SC_PUBLISH
    } scanState_t;

    // one increment request into the bank
    typedef struct packed {
        logic valid;
        bin_t bin;
    } binHit_t;

    // frame end strobe, tagged with the pass it closes
    typedef struct packed {
        logic   done;
        phase_t phase;
    } frameEnd_t;

    // published peak pair
    typedef struct packed {
        bin_t coarse;
        bin_t fine;
    } hisResult_t;

endpackage

/* design/binSelector.sv */
`timescale 1ns/1ps

module binSelector #(
    parameter int FRAME_LEN = 12
) (
    input  logic               clk,
    input  logic               rstN,
    input  logic               wrEn,
    input  hisPkg::sample_t    roughData,
    input  logic               busy,
    input  hisPkg::bin_t       coarsePeak,
    output hisPkg::binHit_t    hit,
    output hisPkg::frameEnd_t  frameEnd
);

    // enough bits to count a whole frame
    localparam int CNT_W = (FRAME_LEN > 1) ? $clog2(FRAME_LEN) : 1;

    // accepted samples in the current frame
    logic [CNT_W-1:0] sampleCnt;

    // pass the current frame belongs to
    hisPkg::phase_t phase;

    // sample taken this edge
    logic accept;

    // last sample of the frame is being taken
    logic lastSample;

    // top bits pick the coarse bin
    hisPkg::bin_t coarseBin;

    // next bits down pick the fine bin
    hisPkg::bin_t fineBin;

    // fine pass only keeps samples inside the coarse peak
    logic inPeak;

    // busy already covers the frame end cycle, so no extra hold-off here
    assign accept = wrEn && !busy;
    assign lastSample = (sampleCnt == CNT_W'(FRAME_LEN - 1));

    assign coarseBin = roughData[hisPkg::SAMPLE_W-1 -: hisPkg::BIN_W];
    assign fineBin = roughData[hisPkg::SAMPLE_W-hisPkg::BIN_W-1 -: hisPkg::BIN_W];
    assign inPeak = (coarseBin == coarsePeak);

    // frame counter and phase toggle
    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            sampleCnt <= '0;
            phase <= hisPkg::PH_COARSE;
        end else if (accept) begin
            if (lastSample) begin
                sampleCnt <= '0;
                // next frame runs the other pass
                phase <= (phase == hisPkg::PH_COARSE) ? hisPkg::PH_FINE
                                                      : hisPkg::PH_COARSE;
            end else begin
                sampleCnt <= sampleCnt + 1'b1;
            end
        end
    end

    // hit request, one per accepted sample at most
    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            hit <= '0;
        end else begin
            hit.valid <= 1'b0;
            if (accept) begin
                if (phase == hisPkg::PH_COARSE) begin
                    hit.valid <= 1'b1;
                    hit.bin <= coarseBin;
                end else begin
                    // outside samples still count toward the frame
                    hit.valid <= inPeak;
                    hit.bin <= fineBin;
                end
            end
        end
    end

    // frame end pulse, lines up with the last sample's hit
    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            frameEnd.done <= 1'b0;
            frameEnd.phase <= hisPkg::PH_COARSE;
        end else begin
            frameEnd.done <= accept && lastSample;
            if (accept && lastSample) begin
                frameEnd.phase <= phase;
            end
        end
    end

endmodule

/* design/binCounterRam.sv */
`timescale 1ns/1ps

module binCounterRam (
    input  logic             clk,
    input  logic             rstN,
    input  hisPkg::binHit_t  hit,
    input  logic             rdEn,
    input  hisPkg::bin_t     rdAddr,
    output hisPkg::count_t   rdData
);

    // one saturating counter per bin
    hisPkg::count_t bank [hisPkg::BIN_NUM];

    // counter at the hit address
    hisPkg::count_t hitCount;

    // stop counting once the bin is full
    logic saturated;

    assign hitCount = bank[hit.bin];
    assign saturated = (hitCount == '1);

    // increment on hit, clear on read
    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            for (int i = 0; i < hisPkg::BIN_NUM; i++) begin
                bank[i] <= '0;
            end
        end else begin
            if (hit.valid && !saturated) begin
                bank[hit.bin] <= hitCount + 1'b1;
            end
            // scan read empties the entry for the next frame
            // producer is held off during a scan, so no same-edge clash
            if (rdEn) begin
                bank[rdAddr] <= '0;
            end
        end
    end

    // registered read port, one cycle latency
    always_ff @(posedge clk) begin
        if (rdEn) begin
            rdData <= bank[rdAddr];
        end
    end

endmodule

/* design/peakFinder.sv */
`timescale 1ns/1ps

module peakFinder (
    input  logic                clk,
    input  logic                rstN,
    input  hisPkg::frameEnd_t   frameEnd,
    input  hisPkg::count_t      rdData,
    output logic                rdEn,
    output hisPkg::bin_t        rdAddr,
    output logic                busy,
    output hisPkg::bin_t        coarsePeak,
    output hisPkg::hisResult_t  result,
    output logic                resultValid
);

    hisPkg::scanState_t state;

    // pass of the frame being scanned
    hisPkg::phase_t scanPhase;

    // rdData is valid this cycle, and for which bin
    logic rdValid;
    hisPkg::bin_t rdBin;

    // running maximum
    hisPkg::count_t maxCount;
    hisPkg::bin_t maxBin;

    // scan starts this edge
    logic scanStart;

    assign scanStart = (state == hisPkg::SC_IDLE) && frameEnd.done;

    // one read per cycle while sweeping the bank
    assign rdEn = (state == hisPkg::SC_READ);

    // raised with the frame end strobe too, so the sample
    // right behind the last one is already held off
    assign busy = (state != hisPkg::SC_IDLE) || frameEnd.done;

    // scan sequencing
    // READ x16, LAST drains the final read, PUBLISH latches the peak
    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            state <= hisPkg::SC_IDLE;
            rdAddr <= '0;
            scanPhase <= hisPkg::PH_COARSE;
        end else begin
            case (state)
                hisPkg::SC_IDLE: begin
                    if (frameEnd.done) begin
                        state <= hisPkg::SC_READ;
                        rdAddr <= '0;
                        scanPhase <= frameEnd.phase;
                    end
                end
                hisPkg::SC_READ: begin
                    // address wraps back to 0 after the top bin
                    rdAddr <= rdAddr + 1'b1;
                    if (rdAddr == '1) begin
                        state <= hisPkg::SC_LAST;
                    end
                end
                hisPkg::SC_LAST: begin
                    state <= hisPkg::SC_PUBLISH;
                end
                hisPkg::SC_PUBLISH: begin
                    state <= hisPkg::SC_IDLE;
                end
                default: begin
                    state <= hisPkg::SC_IDLE;
                end
            endcase
        end
    end

    // compare stage, one cycle behind the read
    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            rdValid <= 1'b0;
            rdBin <= '0;
            maxCount <= '0;
            maxBin <= '0;
        end else begin
            rdValid <= rdEn;
            rdBin <= rdAddr;
            if (scanStart) begin
                // empty histogram falls back to bin 0
                maxCount <= '0;
                maxBin <= '0;
            end else if (rdValid && (rdData > maxCount)) begin
                // strict compare, ties keep the lower bin
                maxCount <= rdData;
                maxBin <= rdBin;
            end
        end
    end

    // peak outputs
    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            coarsePeak <= '0;
            result <= '0;
            resultValid <= 1'b0;
        end else begin
            resultValid <= 1'b0;
            if (state == hisPkg::SC_PUBLISH) begin
                if (scanPhase == hisPkg::PH_COARSE) begin
                    // coarse peak only steers the fine pass
                    coarsePeak <= maxBin;
                end else begin
                    result.coarse <= coarsePeak;
                    result.fine <= maxBin;
                    resultValid <= 1'b1;
                end
            end
        end
    end

endmodule

/* design/hisBuilder.sv */
`timescale 1ns/1ps

module hisBuilder #(
    parameter int FRAME_LEN = 12
) (
    input  logic                clk,
    input  logic                rstN,
    input  logic                wrEn,
    input  hisPkg::sample_t     roughData,
    output hisPkg::hisResult_t  result,
    output logic                resultValid,
    output logic                busy
);

    // selector to bank
    hisPkg::binHit_t hit;

    // selector to peak finder
    hisPkg::frameEnd_t frameEnd;

    // peak finder back to selector
    hisPkg::bin_t coarsePeak;

    // scan read port
    logic rdEn;
    hisPkg::bin_t rdAddr;
    hisPkg::count_t rdData;

    // frame counting and binning
    binSelector #(
        .FRAME_LEN (FRAME_LEN)
    ) binSelector_i (
        .clk        (clk),
        .rstN       (rstN),
        .wrEn       (wrEn),
        .roughData  (roughData),
        .busy       (busy),
        .coarsePeak (coarsePeak),
        .hit        (hit),
        .frameEnd   (frameEnd)
    );

    // 16 bin counter bank
    binCounterRam binCounterRam_i (
        .clk    (clk),
        .rstN   (rstN),
        .hit    (hit),
        .rdEn   (rdEn),
        .rdAddr (rdAddr),
        .rdData (rdData)
    );

    // scan and peak pick
    peakFinder peakFinder_i (
        .clk         (clk),
        .rstN        (rstN),
        .frameEnd    (frameEnd),
        .rdData      (rdData),
        .rdEn        (rdEn),
        .rdAddr      (rdAddr),
        .busy        (busy),
        .coarsePeak  (coarsePeak),
        .result      (result),
        .resultValid (resultValid)
    );

endmodule

/* test/hisTbModel.svh */
`ifndef HIS_TB_MODEL_SVH
`define HIS_TB_MODEL_SVH

// reference model and compare tasks for hisBuilderTb
// relies on FRAME_SAMPLES, ROW_SAMPLES, checksDone and abortRun from the including module

// largest value a bin counter can hold
localparam int COUNT_MAX = (1 << hisPkg::COUNT_W) - 1;

// one more photon, unless the bin is already full
function automatic int bumpCount(input int count);
    return (count < COUNT_MAX) ? count + 1 : count;
endfunction

// fullest bin, lowest index wins a tie, empty gives bin 0
function automatic hisPkg::bin_t pickPeak(input int counts [hisPkg::BIN_NUM]);
    int best;
    hisPkg::bin_t bestBin;
    best = 0;
    bestBin = '0;
    for (int b = 0; b < hisPkg::BIN_NUM; b++) begin
        if (counts[b] > best) begin
            best = counts[b];
            bestBin = hisPkg::bin_t'(b);
        end
    end
    return bestBin;
endfunction

// expected peak pair for one coarse frame followed by one fine frame
function automatic hisPkg::hisResult_t expectPeaks(input hisPkg::sample_t samples [ROW_SAMPLES]);
    int coarseCounts [hisPkg::BIN_NUM];
    int fineCounts [hisPkg::BIN_NUM];
    hisPkg::hisResult_t peaks;
    int top;
    int mid;
    for (int b = 0; b < hisPkg::BIN_NUM; b++) begin
        coarseCounts[b] = 0;
        fineCounts[b] = 0;
    end
    // coarse frame, top bits only
    for (int i = 0; i < FRAME_SAMPLES; i++) begin
        top = int'(samples[i]) >> (hisPkg::SAMPLE_W - hisPkg::BIN_W);
        coarseCounts[top] = bumpCount(coarseCounts[top]);
    end
    peaks.coarse = pickPeak(coarseCounts);
    // fine frame, next bits down, inside the coarse peak only
    for (int i = FRAME_SAMPLES; i < ROW_SAMPLES; i++) begin
        top = int'(samples[i]) >> (hisPkg::SAMPLE_W - hisPkg::BIN_W);
        mid = (int'(samples[i]) >> 2) % hisPkg::BIN_NUM;
        if (top == int'(peaks.coarse)) begin
            fineCounts[mid] = bumpCount(fineCounts[mid]);
        end
    end
    peaks.fine = pickPeak(fineCounts);
    return peaks;
endfunction

// whole published pair
task automatic checkResult(input string name, input hisPkg::hisResult_t expected,
                           input hisPkg::hisResult_t actual);
    checksDone++;
    if (actual !== expected) begin
        abortRun($sformatf("error %s: expected %h, actual %h", name, expected, actual));
    end
endtask

// one bin index
task automatic checkBin(input string name, input hisPkg::bin_t expected,
                        input hisPkg::bin_t actual);
    checksDone++;
    if (actual !== expected) begin
        abortRun($sformatf("error %s: expected %0d, actual %0d", name, expected, actual));
    end
endtask

// cycles between last fine sample and resultValid
task automatic checkLatency(input string name, input int expected, input int actual);
    checksDone++;
    if (actual != expected) begin
        abortRun($sformatf("error %s: expected %0d, actual %0d", name, expected, actual));
    end
endtask

// single level such as busy
task automatic checkLevel(input string name, input logic expected, input logic actual);
    checksDone++;
    if (actual !== expected) begin
        abortRun($sformatf("error %s: expected %b, actual %b", name, expected, actual));
    end
endtask

`endif

/* test/hisBuilderTb.sv */
`timescale 1ns/1ps

module hisBuilderTb;

    localparam int CLK_PERIOD = 8;
    localparam int RESET_CYCLES = 5;
    localparam int DRIVE_DELAY = 1;
    localparam int FRAME_SAMPLES = 12;
    localparam int ROW_SAMPLES = 2 * FRAME_SAMPLES;
    // 16 reads, drain, compare, publish
    localparam int SCAN_CYCLES = 19;
    localparam int RANDOM_ROWS = 4;

    // one table entry, coarse frame then fine frame
    typedef struct {
        string              name;
        int                 junkCount;
        hisPkg::sample_t    junkData;
        hisPkg::sample_t    samples [ROW_SAMPLES];
        hisPkg::hisResult_t expected;
    } testRow_t;

    logic               clk;
    logic               rstN;
    logic               wrEn;
    hisPkg::sample_t    roughData;
    hisPkg::hisResult_t result;
    logic               resultValid;
    logic               busy;

    testRow_t testTable [$];
    int checksDone;
    logic tableReady;

    // pair published by the row before, must hold through the next coarse scan
    hisPkg::hisResult_t lastExpected;
    logic haveLast;

    // print the reason, then stop the run
    task automatic abortRun(input string reason);
        $display("%s", reason);
        $display("Checks failed");
        $fatal(1, "run stopped");
    endtask

    `include "hisTbModel.svh"

    hisBuilder #(
        .FRAME_LEN (FRAME_SAMPLES)
    ) dut_i (
        .clk         (clk),
        .rstN        (rstN),
        .wrEn        (wrEn),
        .roughData   (roughData),
        .result      (result),
        .resultValid (resultValid),
        .busy        (busy)
    );

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    // hand-checked row
    task automatic addRow(input string name, input int junkCount, input hisPkg::sample_t junkData,
                          input hisPkg::sample_t samples [ROW_SAMPLES],
                          input hisPkg::bin_t expCoarse, input hisPkg::bin_t expFine);
        testRow_t row;
        row.name = name;
        row.junkCount = junkCount;
        row.junkData = junkData;
        row.samples = samples;
        row.expected.coarse = expCoarse;
        row.expected.fine = expFine;
        testTable.push_back(row);
    endtask

    // random row, expected pair from the model
    task automatic addRandomRow(input string name);
        testRow_t row;
        hisPkg::bin_t focus;
        focus = hisPkg::bin_t'($urandom % hisPkg::BIN_NUM);
        row.name = name;
        row.junkCount = $urandom % 3;
        row.junkData = hisPkg::sample_t'($urandom);
        for (int i = 0; i < ROW_SAMPLES; i++) begin
            // most draws land in one coarse bin so the fine pass gets hits
            if (($urandom % 4) != 0) begin
                row.samples[i] = {focus, 6'($urandom)};
            end else begin
                row.samples[i] = hisPkg::sample_t'($urandom);
            end
        end
        row.expected = expectPeaks(row.samples);
        testTable.push_back(row);
    endtask

    task automatic buildTable();
        // reference-style values, bin 7 wins then fine 15
        addRow("refPeak", 0, '0,
            '{10'h1ff, 10'h1ff, 10'h1ff, 10'h1ff, 10'h1ff, 10'h2bc, 10'h2bc, 10'h2bc,
              10'h05a, 10'h05a, 10'h05a, 10'h2bc,
              10'h1ff, 10'h1ff, 10'h1ff, 10'h1d4, 10'h1d4, 10'h2bc, 10'h05a, 10'h1ff,
              10'h2bc, 10'h05a, 10'h1c0, 10'h1ff}, 4'd7, 4'd15);
        // three-way coarse tie, two-way fine tie
        addRow("lowestTie", 0, '0,
            '{10'h0c0, 10'h240, 10'h300, 10'h0c4, 10'h244, 10'h304, 10'h0c8, 10'h248,
              10'h308, 10'h0cc, 10'h24c, 10'h30c,
              10'h0e0, 10'h0c8, 10'h0e1, 10'h0c9, 10'h0e2, 10'h0ca, 10'h240, 10'h241,
              10'h300, 10'h301, 10'h040, 10'h3ff}, 4'd3, 4'd2);
        // fine frame entirely outside bin 5, junk would land in fine 15
        addRow("fineOutside", 2, 10'h17c,
            '{10'h17c, 10'h150, 10'h17c, 10'h160, 10'h140, 10'h144, 10'h17c, 10'h168,
              10'h170, 10'h14c, 10'h15c, 10'h17f,
              10'h3ff, 10'h000, 10'h1ff, 10'h200, 10'h100, 10'h13f, 10'h180, 10'h2aa,
              10'h055, 10'h3c0, 10'h0f0, 10'h1bf}, 4'd5, 4'd0);
        // five junk samples during the scan would outvote fine 4
        addRow("dropBusy", 5, 10'h33c,
            '{10'h304, 10'h304, 10'h0c0, 10'h304, 10'h0c0, 10'h304, 10'h0c0, 10'h304,
              10'h0c0, 10'h304, 10'h0c0, 10'h304,
              10'h310, 10'h0c0, 10'h310, 10'h320, 10'h000, 10'h310, 10'h320, 10'h3ff,
              10'h310, 10'h320, 10'h100, 10'h200}, 4'd12, 4'd4);
        // leftovers from the row before would make bin 4 win
        addRow("backToBack", 0, '0,
            '{10'h004, 10'h040, 10'h080, 10'h0c0, 10'h100, 10'h004, 10'h140, 10'h180,
              10'h1c0, 10'h200, 10'h240, 10'h280,
              10'h008, 10'h008, 10'h004, 10'h3c0, 10'h3c0, 10'h3c0, 10'h3c0, 10'h3c0,
              10'h3c0, 10'h3c0, 10'h3c0, 10'h3c0}, 4'd0, 4'd2);
        for (int r = 0; r < RANDOM_ROWS; r++) begin
            addRandomRow($sformatf("random%0d", r));
        end
    endtask

    // entered 1 ns after an edge, returns 1 ns after the next one
    task automatic driveSample(input hisPkg::sample_t value);
        wrEn = 1'b1;
        roughData = value;
        @(posedge clk);
        #DRIVE_DELAY;
    endtask

    task automatic waitIdle();
        while (busy) begin
            @(posedge clk);
            #DRIVE_DELAY;
        end
    endtask

    task automatic runRow(input testRow_t row);
        int latency;
        for (int i = 0; i < FRAME_SAMPLES; i++) begin
            driveSample(row.samples[i]);
        end
        wrEn = 1'b0;
        // coarse scan running, these must not count
        for (int j = 0; j < row.junkCount; j++) begin
            checkLevel({row.name, " busy while dropping"}, 1'b1, busy);
            driveSample(row.junkData);
        end
        wrEn = 1'b0;
        waitIdle();
        // coarse scan publishes nothing outside
        checkLevel({row.name, " no valid after coarse"}, 1'b0, resultValid);
        if (haveLast) begin
            checkResult({row.name, " held"}, lastExpected, result);
        end
        for (int i = FRAME_SAMPLES; i < ROW_SAMPLES; i++) begin
            driveSample(row.samples[i]);
        end
        wrEn = 1'b0;
        // edges from the last accepted sample up to resultValid
        latency = 0;
        while (!resultValid) begin
            @(posedge clk);
            #DRIVE_DELAY;
            latency++;
        end
        checkLatency({row.name, " latency"}, SCAN_CYCLES, latency);
        checkBin({row.name, " coarse"}, row.expected.coarse, result.coarse);
        checkBin({row.name, " fine"}, row.expected.fine, result.fine);
        lastExpected = row.expected;
        haveLast = 1'b1;
        waitIdle();
    endtask

    // watchdog sized from the table
    initial begin
        int limitCycles;
        wait (tableReady);
        limitCycles = testTable.size() * ROW_SAMPLES + testTable.size() * 2 * SCAN_CYCLES
                      + RESET_CYCLES;
        limitCycles = limitCycles + limitCycles / 2;
        repeat (limitCycles) @(posedge clk);
        abortRun("no result arrived in time, watchdog ended the run");
    end

    initial begin
        void'($urandom(8));
        rstN = 1'b0;
        wrEn = 1'b0;
        roughData = '0;
        checksDone = 0;
        tableReady = 1'b0;
        lastExpected = '0;
        haveLast = 1'b0;
        buildTable();
        tableReady = 1'b1;
        repeat (RESET_CYCLES) @(posedge clk);
        #DRIVE_DELAY;
        rstN = 1'b1;
        @(posedge clk);
        #DRIVE_DELAY;
        checkLevel("busyAfterReset", 1'b0, busy);
        checkLevel("validAfterReset", 1'b0, resultValid);
        foreach (testTable[r]) begin
            runRow(testTable[r]);
        end
        if (checksDone == 0) begin
            abortRun("no checks were run");
        end else begin
            $display("All checks passed");
            $finish;
        end
    end

endmodule

/* filelist.f */
+incdir+test
design/hisPkg.sv
design/binSelector.sv
design/binCounterRam.sv
design/peakFinder.sv
design/hisBuilder.sv
test/hisBuilderTb.sv
